//--- rom_macros.svh
//******************************
// Sizes and region offsets of the ROM image
// SDRAM addresses count 16-bit words, ioctl addresses count bytes
// Regions must not overlap; the PROM area sits above all of them
//******************************

`ifndef ROM_MACROS_SVH
`define ROM_MACROS_SVH

// SDRAM word address and host download byte address widths
`define ROM_AW 22
`define IOCTL_AW 22

// Client address widths
// Main and sound count bytes, the character layer counts 16-bit words
`define MAIN_AW 16
`define SND_AW 15
`define CHAR_AW 13

// Region start in SDRAM words
`define MAIN_OFFSET 22'h0_0000
`define SND_OFFSET 22'h0_8000
`define CHAR_OFFSET 22'h0_C000

// Byte address of the first PROM byte in the download stream
`define PROM_START 22'h1_C000

// PROM layout, six devices of 256 entries
`define PROM_COUNT 6
`define PROM_AW 8
// Enough bits to number every PROM
`define PROM_SEL_W 3

`endif

//--- rom_pkg.sv
//******************************
// Shared enums of the ROM side
// rom_client_e order sets the arbiter priority
//******************************

package rom_pkg;

    // Lowest value wins arbitration
    typedef enum logic [1:0] {
        CLIENT_MAIN = 2'd0,
        CLIENT_SND  = 2'd1,
        CLIENT_CHAR = 2'd2
    } rom_client_e;

    // SDRAM read exchange
    typedef enum logic [1:0] {
        PORT_IDLE = 2'd0,
        PORT_REQ  = 2'd1,
        PORT_WAIT = 2'd2
    } port_state_e;

    // Destination of a downloaded byte
    typedef enum logic {
        REGION_SDRAM = 1'b0,
        REGION_PROM  = 1'b1
    } region_e;

endpackage

//--- prog_loader.sv
//******************************
// Download bytes become SDRAM writes one cycle after ioctl_wr
// Bytes past the PROM area are dropped
// Writes count only while downloading is high
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module prog_loader import rom_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   downloading,
    input  logic [`IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]             ioctl_data,
    input  logic                   ioctl_wr,
    output logic [`ROM_AW-1:0]     prog_addr,
    output logic [7:0]             prog_data,
    output logic [1:0]             prog_mask,
    output logic                   prog_we,
    output logic [`PROM_COUNT-1:0] prom_we
);

    localparam int PROM_BYTES = `PROM_COUNT << `PROM_AW;

    region_e                 region;
    logic [`IOCTL_AW-1:0]    prom_rel;
    logic [`PROM_SEL_W-1:0]  prom_sel;
    logic                    prom_hit;
    logic                    wr_en;

    assign wr_en    = ioctl_wr && downloading;
    assign region   = (ioctl_addr >= `PROM_START) ? REGION_PROM : REGION_SDRAM;
    assign prom_rel = ioctl_addr - `PROM_START;
    // Each PROM owns one 256-byte block
    assign prom_sel = prom_rel[`PROM_AW +: `PROM_SEL_W];
    assign prom_hit = (prom_rel < PROM_BYTES);

    // Write strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prog_we <= wr_en && (region == REGION_SDRAM);
            prom_we <= '0;
            if (wr_en && (region == REGION_PROM) && prom_hit) begin
                prom_we[prom_sel] <= 1'b1;
            end
        end
    end

    // Address, data and byte lane
    always_ff @(posedge clk) begin
        if (wr_en) begin
            prog_data <= ioctl_data;
            if (region == REGION_SDRAM) begin
                prog_addr <= `ROM_AW'(ioctl_addr >> 1);
                // Mask bit set means that lane is kept
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end else begin
                // PROM entry on the low address bits
                prog_addr <= `ROM_AW'(prom_rel[`PROM_AW-1:0]);
                prog_mask <= 2'b11;
            end
        end
    end

endmodule

//--- rom_slot.sv
//******************************
// One cached 32-bit SDRAM word per client
// ok is combinational, so the client must hold cs and addr until ok
// DW is 8 for byte clients or 16 for half-word clients
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module rom_slot #(
    parameter int                 AW     = 16,
    parameter logic [`ROM_AW-1:0] OFFSET = '0,
    parameter int                 DW     = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               cs,
    input  logic [AW-1:0]      addr,
    output logic [DW-1:0]      data,
    output logic               ok,
    output logic               miss,
    output logic [`ROM_AW-1:0] word_addr,
    input  logic               fill,
    input  logic [31:0]        fill_data
);

    // Address bits that select inside the 32-bit word
    localparam int SH = (DW == 8) ? 2 : 1;

    logic [`ROM_AW-1:0] addr_ext;
    logic [`ROM_AW-1:0] cached_addr;
    logic [31:0]        cached_data;
    logic               valid;
    logic               hit;
    logic [SH-1:0]      sel;

    // 32-bit index, back to an even 16-bit word address
    assign addr_ext  = `ROM_AW'(addr);
    assign word_addr = ((addr_ext >> SH) << 1) + OFFSET;

    assign hit  = valid && (cached_addr == word_addr);
    assign ok   = cs && hit;
    assign miss = cs && !hit;

    // Lower address picks the lower lane
    assign sel  = addr[SH-1:0];
    assign data = cached_data[int'(sel) * DW +: DW];

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (fill) begin
            valid <= 1'b1;
        end
    end

    // Client still holds the missed address when the fill comes
    always_ff @(posedge clk) begin
        if (fill) begin
            cached_addr <= word_addr;
            cached_data <= fill_data;
        end
    end

endmodule

//--- rom_arbiter.sv
//******************************
// Fixed priority, main first, one miss in flight
// No start in the done cycle while the served miss is still up
// game_rst drops 2 cycles after the download ends
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module rom_arbiter import rom_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               downloading,
    input  logic [2:0]         misses,
    input  logic [`ROM_AW-1:0] main_word_addr,
    input  logic [`ROM_AW-1:0] snd_word_addr,
    input  logic [`ROM_AW-1:0] char_word_addr,
    input  logic               port_idle,
    input  logic               port_done,
    output logic [2:0]         fills,
    output logic               start,
    output logic [`ROM_AW-1:0] start_addr,
    output logic               game_rst
);

    rom_client_e choice;
    rom_client_e granted;
    logic        rst_aux;

    always_comb begin
        if (misses[CLIENT_MAIN]) begin
            choice = CLIENT_MAIN;
        end else if (misses[CLIENT_SND]) begin
            choice = CLIENT_SND;
        end else begin
            choice = CLIENT_CHAR;
        end
    end

    always_comb begin
        case (choice)
            CLIENT_MAIN: start_addr = main_word_addr;
            CLIENT_SND:  start_addr = snd_word_addr;
            default:     start_addr = char_word_addr;
        endcase
    end

    // Slot loads in the done cycle, its miss clears one cycle later
    assign start = port_idle && !port_done && !downloading && (|misses);

    always_ff @(posedge clk) begin
        if (reset) begin
            granted <= CLIENT_MAIN;
        end else if (start) begin
            granted <= choice;
        end
    end

    // Return the data to whoever asked
    assign fills = port_done ? (3'b001 << granted) : 3'b000;

    // Two-stage hold after download
    always_ff @(posedge clk) begin
        if (reset || downloading) begin
            rst_aux  <= 1'b1;
            game_rst <= 1'b1;
        end else begin
            rst_aux  <= 1'b0;
            game_rst <= rst_aux;
        end
    end

endmodule

//--- sdram_port.sv
//******************************
// SDRAM read port with the req/ack/rdy exchange
// sdram_req and sdram_addr hold until sdram_ack
// loop_rst or downloading drops a read in flight without done
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module sdram_port import rom_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               loop_rst,
    input  logic               downloading,
    input  logic               start,
    input  logic [`ROM_AW-1:0] start_addr,
    input  logic               sdram_ack,
    input  logic               data_rdy,
    input  logic [31:0]        data_read,
    input  logic               pending,
    output logic               sdram_req,
    output logic [`ROM_AW-1:0] sdram_addr,
    output logic               port_idle,
    output logic               port_done,
    output logic [31:0]        port_data,
    output logic               refresh_en
);

    port_state_e state;
    logic        abort;

    assign abort     = loop_rst || downloading;
    assign port_idle = (state == PORT_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= PORT_IDLE;
            sdram_req  <= 1'b0;
            port_done  <= 1'b0;
            refresh_en <= 1'b0;
        end else begin
            port_done  <= 1'b0;
            // Refresh only with nothing waiting for the port
            refresh_en <= port_idle && !pending;
            if (abort) begin
                state     <= PORT_IDLE;
                sdram_req <= 1'b0;
            end else begin
                case (state)
                    PORT_IDLE: if (start) begin
                        sdram_req <= 1'b1;
                        state     <= PORT_REQ;
                    end
                    PORT_REQ: if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= PORT_WAIT;
                    end
                    PORT_WAIT: if (data_rdy) begin
                        port_done <= 1'b1;
                        state     <= PORT_IDLE;
                    end
                    default: state <= PORT_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port_idle && start) begin
            sdram_addr <= start_addr;
        end
        if ((state == PORT_WAIT) && data_rdy) begin
            port_data <= data_read;
        end
    end

endmodule

//--- rom_top.sv
//******************************
// ROM side of the game core
// Clients hold cs and address until ok
// The SDRAM controller sits outside
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module rom_top import rom_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    // Host download
    input  logic                   downloading,
    input  logic [`IOCTL_AW-1:0]   ioctl_addr,
    input  logic [7:0]             ioctl_data,
    input  logic                   ioctl_wr,
    output logic [`ROM_AW-1:0]     prog_addr,
    output logic [7:0]             prog_data,
    output logic [1:0]             prog_mask,
    output logic                   prog_we,
    output logic [`PROM_COUNT-1:0] prom_we,
    output logic                   game_rst,
    // ROM clients
    input  logic                   main_cs,
    input  logic [`MAIN_AW-1:0]    main_addr,
    output logic [7:0]             main_data,
    output logic                   main_ok,
    input  logic                   snd_cs,
    input  logic [`SND_AW-1:0]     snd_addr,
    output logic [7:0]             snd_data,
    output logic                   snd_ok,
    input  logic                   char_cs,
    input  logic [`CHAR_AW-1:0]    char_addr,
    output logic [15:0]            char_data,
    output logic                   char_ok,
    // SDRAM read side
    output logic                   sdram_req,
    input  logic                   sdram_ack,
    input  logic                   data_rdy,
    output logic [`ROM_AW-1:0]     sdram_addr,
    input  logic [31:0]            data_read,
    input  logic                   loop_rst,
    output logic                   refresh_en
);

    logic [2:0]         misses;
    logic [2:0]         fills;
    logic [`ROM_AW-1:0] main_word_addr;
    logic [`ROM_AW-1:0] snd_word_addr;
    logic [`ROM_AW-1:0] char_word_addr;
    logic               start;
    logic [`ROM_AW-1:0] start_addr;
    logic               port_idle;
    logic               port_done;
    logic [31:0]        port_data;
    logic               pending;
    logic               flush;

    assign pending = |misses;
    assign flush   = loop_rst || downloading;

    prog_loader u_loader (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(.AW(`MAIN_AW), .OFFSET(`MAIN_OFFSET), .DW(8)) u_main_slot (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .cs        (main_cs),
        .addr      (main_addr),
        .data      (main_data),
        .ok        (main_ok),
        .miss      (misses[CLIENT_MAIN]),
        .word_addr (main_word_addr),
        .fill      (fills[CLIENT_MAIN]),
        .fill_data (port_data)
    );

    rom_slot #(.AW(`SND_AW), .OFFSET(`SND_OFFSET), .DW(8)) u_snd_slot (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .cs        (snd_cs),
        .addr      (snd_addr),
        .data      (snd_data),
        .ok        (snd_ok),
        .miss      (misses[CLIENT_SND]),
        .word_addr (snd_word_addr),
        .fill      (fills[CLIENT_SND]),
        .fill_data (port_data)
    );

    // Character ROM is read as 16-bit words
    rom_slot #(.AW(`CHAR_AW), .OFFSET(`CHAR_OFFSET), .DW(16)) u_char_slot (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .cs        (char_cs),
        .addr      (char_addr),
        .data      (char_data),
        .ok        (char_ok),
        .miss      (misses[CLIENT_CHAR]),
        .word_addr (char_word_addr),
        .fill      (fills[CLIENT_CHAR]),
        .fill_data (port_data)
    );

    rom_arbiter u_arbiter (
        .clk            (clk),
        .reset          (reset),
        .downloading    (downloading),
        .misses         (misses),
        .main_word_addr (main_word_addr),
        .snd_word_addr  (snd_word_addr),
        .char_word_addr (char_word_addr),
        .port_idle      (port_idle),
        .port_done      (port_done),
        .fills          (fills),
        .start          (start),
        .start_addr     (start_addr),
        .game_rst       (game_rst)
    );

    sdram_port u_port (
        .clk         (clk),
        .reset       (reset),
        .loop_rst    (loop_rst),
        .downloading (downloading),
        .start       (start),
        .start_addr  (start_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .pending     (pending),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .port_idle   (port_idle),
        .port_done   (port_done),
        .port_data   (port_data),
        .refresh_en  (refresh_en)
    );

endmodule

//--- rom_assert.sv
//******************************
// Handshake assertions, bound into rom_top
// fail_count is read by the testbench
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module rom_assert (
    input logic                   clk,
    input logic                   reset,
    input logic                   loop_rst,
    input logic                   downloading,
    input logic                   sdram_req,
    input logic                   sdram_ack,
    input logic [`ROM_AW-1:0]     sdram_addr,
    input logic                   refresh_en,
    input logic [`PROM_COUNT-1:0] prom_we
);

    int fail_count = 0;

    // Request and address stay put until the controller takes them
    a_req_hold: assert property (@(posedge clk) disable iff (reset || loop_rst || downloading)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            fail_count++;
            $error("sdram_req or sdram_addr changed before sdram_ack");
        end

    a_no_req_download: assert property (@(posedge clk) disable iff (reset)
        downloading && $past(downloading) |-> !sdram_req)
        else begin
            fail_count++;
            $error("sdram_req high during a download");
        end

    a_prom_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(prom_we))
        else begin
            fail_count++;
            $error("more than one prom_we bit high");
        end

    a_refresh_idle: assert property (@(posedge clk) disable iff (reset)
        !(refresh_en && sdram_req))
        else begin
            fail_count++;
            $error("refresh_en high together with sdram_req");
        end

endmodule

bind rom_top rom_assert u_assert (.*);

//--- rom_tb.sv
//******************************
// Directed testbench for rom_top
// SDRAM model answers with random ack and rdy delays
// Model memory covers the three client regions only
//******************************

`timescale 1ns/100ps
`include "rom_macros.svh"

module rom_tb import rom_pkg::*; ();

    // Whole sequence stays far below this bound
    localparam int CYCLE_LIMIT = 20000;
    localparam int MEM_WORDS   = 32768;

    logic                   clk;
    logic                   reset;
    logic                   downloading;
    logic [`IOCTL_AW-1:0]   ioctl_addr;
    logic [7:0]             ioctl_data;
    logic                   ioctl_wr;
    logic [`ROM_AW-1:0]     prog_addr;
    logic [7:0]             prog_data;
    logic [1:0]             prog_mask;
    logic                   prog_we;
    logic [`PROM_COUNT-1:0] prom_we;
    logic                   game_rst;
    logic                   main_cs;
    logic [`MAIN_AW-1:0]    main_addr;
    logic [7:0]             main_data;
    logic                   main_ok;
    logic                   snd_cs;
    logic [`SND_AW-1:0]     snd_addr;
    logic [7:0]             snd_data;
    logic                   snd_ok;
    logic                   char_cs;
    logic [`CHAR_AW-1:0]    char_addr;
    logic [15:0]            char_data;
    logic                   char_ok;
    logic                   sdram_req;
    logic                   sdram_ack;
    logic                   data_rdy;
    logic [`ROM_AW-1:0]     sdram_addr;
    logic [31:0]            data_read;
    logic                   loop_rst;
    logic                   refresh_en;

    logic [31:0]        mem [MEM_WORDS];
    integer             seed      = 41837;
    int                 errors    = 0;
    int                 cycles    = 0;
    int                 req_count = 0;
    logic               req_prev  = 1'b0;
    logic [`ROM_AW-1:0] req_addrs [$];

    rom_top u_dut (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the DUT did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Count each new SDRAM request and keep its address
    always @(posedge clk) begin
        req_prev <= sdram_req;
        if (sdram_req && !req_prev) begin
            req_count <= req_count + 1;
            req_addrs.push_back(sdram_addr);
        end
    end

    // SDRAM controller model
    initial begin
        int                 ack_wait;
        int                 rdy_wait;
        logic [`ROM_AW-1:0] req_word;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #1;
            if (sdram_req === 1'b1) begin
                ack_wait = $unsigned($random(seed)) % 4;
                rdy_wait = 1 + $unsigned($random(seed)) % 4;
                repeat (ack_wait) begin
                    @(posedge clk);
                    #1;
                end
                req_word  = sdram_addr;
                sdram_ack = 1'b1;
                @(posedge clk);
                #1;
                sdram_ack = 1'b0;
                repeat (rdy_wait - 1) begin
                    @(posedge clk);
                    #1;
                end
                data_rdy  = 1'b1;
                data_read = mem[15'(req_word >> 1)];
                @(posedge clk);
                #1;
                data_rdy = 1'b0;
            end
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_lanes(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word16(input string name, input logic [15:0] exp,
                                input logic [15:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_strobe(input string name, input logic [`PROM_COUNT-1:0] exp,
                                input logic [`PROM_COUNT-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`ROM_AW-1:0] exp,
                              input logic [`ROM_AW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_client(input string name, input rom_client_e exp,
                                input rom_client_e act);
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    function automatic logic client_ok(input rom_client_e client);
        case (client)
            CLIENT_MAIN: return main_ok;
            CLIENT_SND:  return snd_ok;
            default:     return char_ok;
        endcase
    endfunction

    // Region that an SDRAM word address falls in
    function automatic rom_client_e client_of(input logic [`ROM_AW-1:0] addr);
        if (addr >= `CHAR_OFFSET) begin
            return CLIENT_CHAR;
        end else if (addr >= `SND_OFFSET) begin
            return CLIENT_SND;
        end
        return CLIENT_MAIN;
    endfunction

    // Model data seen by a client, bytes zero extended
    function automatic logic [15:0] expected_data(input rom_client_e client,
                                                  input logic [15:0] addr);
        logic [`ROM_AW-1:0] word;
        logic [31:0]        line;
        logic [4:0]         lane;
        case (client)
            CLIENT_MAIN: word = `MAIN_OFFSET + `ROM_AW'(addr >> 1);
            CLIENT_SND:  word = `SND_OFFSET + `ROM_AW'(addr[14:0] >> 1);
            default:     word = `CHAR_OFFSET + `ROM_AW'(addr[12:0]);
        endcase
        line = mem[15'(word >> 1)];
        if (client == CLIENT_CHAR) begin
            lane = {addr[0], 4'b0000};
            line = line >> lane;
            return line[15:0];
        end
        lane = {addr[1:0], 3'b000};
        line = line >> lane;
        return {8'h00, line[7:0]};
    endfunction

    task automatic check_client_data(input rom_client_e client, input logic [15:0] addr,
                                     input string name);
        logic [15:0] expected;
        expected = expected_data(client, addr);
        case (client)
            CLIENT_MAIN: check_byte(name, expected[7:0], main_data);
            CLIENT_SND:  check_byte(name, expected[7:0], snd_data);
            default:     check_word16(name, expected, char_data);
        endcase
    endtask

    task automatic drive_client(input rom_client_e client, input logic [15:0] addr);
        case (client)
            CLIENT_MAIN: begin
                main_addr = addr;
                main_cs   = 1'b1;
            end
            CLIENT_SND: begin
                snd_addr = addr[14:0];
                snd_cs   = 1'b1;
            end
            default: begin
                char_addr = addr[12:0];
                char_cs   = 1'b1;
            end
        endcase
    endtask

    task automatic release_clients();
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        char_cs = 1'b0;
    endtask

    // Hold cs until ok, latency counts cycles without ok
    task automatic read_client(input rom_client_e client, input logic [15:0] addr,
                               input string name, output int latency);
        latency = 0;
        drive_client(client, addr);
        #1;
        while (!client_ok(client)) begin
            @(posedge clk);
            #2;
            latency++;
        end
        check_client_data(client, addr, name);
        @(posedge clk);
        #1;
        release_clients();
    endtask

    task automatic pulse_loop_rst();
        loop_rst = 1'b1;
        @(posedge clk);
        #1;
        loop_rst = 1'b0;
    endtask

    task automatic send_byte(input logic [`IOCTL_AW-1:0] addr, input logic [7:0] data);
        logic [`IOCTL_AW-1:0] rel;
        logic [31:0]          word;
        logic [4:0]           lane;
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;
        if (addr >= `PROM_START) begin
            rel = addr - `PROM_START;
            check_bit("prom byte prog_we", 1'b0, prog_we);
            check_strobe("prom select", 6'b000001 << (rel >> 8), prom_we);
            check_byte("prom entry", rel[7:0], prog_addr[7:0]);
            check_byte("prom data", data, prog_data);
        end else begin
            check_bit("sdram byte prog_we", 1'b1, prog_we);
            check_strobe("sdram byte prom_we", '0, prom_we);
            check_addr("prog_addr", addr >> 1, prog_addr);
            check_byte("prog_data", data, prog_data);
            check_lanes("prog_mask", addr[0] ? 2'b01 : 2'b10, prog_mask);
            // Even byte is the low byte of its 16-bit word
            lane = {addr[1:0], 3'b000};
            word = mem[15'(addr >> 2)];
            word = (word & ~(32'h0000_00FF << lane)) | (32'(data) << lane);
            mem[15'(addr >> 2)] = word;
        end
        check_bit("game_rst in download", 1'b1, game_rst);
        @(posedge clk);
        #1;
        check_bit("prog_we pulse width", 1'b0, prog_we);
        check_strobe("prom_we pulse width", '0, prom_we);
    endtask

    task automatic test_reset_state();
        check_bit("reset sdram_req", 1'b0, sdram_req);
        check_bit("reset prog_we", 1'b0, prog_we);
        check_strobe("reset prom_we", '0, prom_we);
        check_bit("reset refresh_en", 1'b0, refresh_en);
        check_bit("reset game_rst", 1'b1, game_rst);
    endtask

    task automatic test_sdram_download();
        downloading = 1'b1;
        for (int i = 0; i < 24; i++) begin
            send_byte(`IOCTL_AW'($unsigned($random(seed)) % `PROM_START), 8'($random(seed)));
        end
    endtask

    task automatic test_prom_download();
        logic [7:0] entry;
        for (int k = 0; k < `PROM_COUNT; k++) begin
            entry = 8'($random(seed));
            send_byte(`PROM_START + `IOCTL_AW'(k * 256) + `IOCTL_AW'(entry),
                      8'($random(seed)));
        end
    endtask

    task automatic test_game_reset();
        downloading = 1'b0;
        @(posedge clk);
        #1;
        check_bit("game_rst one cycle after download", 1'b1, game_rst);
        @(posedge clk);
        #1;
        check_bit("game_rst two cycles after download", 1'b0, game_rst);
    endtask

    task automatic test_random_reads();
        int latency;
        for (int i = 0; i < 8; i++) begin
            read_client(CLIENT_MAIN, 16'($random(seed)), "main read", latency);
            read_client(CLIENT_SND, 16'($random(seed)), "sound read", latency);
            read_client(CLIENT_CHAR, 16'($random(seed)), "char read", latency);
        end
    endtask

    task automatic test_slot_hits();
        logic [15:0] addr;
        int          latency;
        int          reqs;
        for (int c = 0; c < 3; c++) begin
            addr = 16'($random(seed));
            read_client(rom_client_e'(c), addr, "hit setup read", latency);
            reqs = req_count;
            // Neighbour in the same 32-bit word
            read_client(rom_client_e'(c), addr ^ 16'h0001, "hit read", latency);
            check_bit("hit ok with cs", 1'b1, latency == 0);
            check_bit("hit without sdram_req", 1'b1, req_count == reqs);
            // Port idle with no miss waiting
            check_bit("refresh_en while idle", 1'b1, refresh_en);
        end
    endtask

    task automatic test_concurrent_misses();
        logic [15:0] main_a;
        logic [15:0] snd_a;
        logic [15:0] char_a;
        int          base;
        int          reqs;
        int          latency;
        pulse_loop_rst();
        main_a = 16'($random(seed));
        snd_a  = 16'($random(seed));
        char_a = 16'($random(seed));
        base   = req_addrs.size();
        drive_client(CLIENT_MAIN, main_a);
        drive_client(CLIENT_SND, snd_a);
        drive_client(CLIENT_CHAR, char_a);
        #1;
        while (!(main_ok && snd_ok && char_ok)) begin
            @(posedge clk);
            #2;
        end
        check_bit("concurrent grant issued", 1'b1, req_addrs.size() > base);
        check_client("first grant", CLIENT_MAIN, client_of(req_addrs[base]));
        check_client_data(CLIENT_MAIN, main_a, "concurrent main read");
        check_client_data(CLIENT_SND, snd_a, "concurrent sound read");
        check_client_data(CLIENT_CHAR, char_a, "concurrent char read");
        @(posedge clk);
        #1;
        release_clients();
        pulse_loop_rst();
        reqs = req_count;
        read_client(CLIENT_MAIN, main_a, "read after loop_rst", latency);
        check_bit("miss after loop_rst", 1'b1, req_count > reqs);
    endtask

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        char_cs     = 1'b0;
        char_addr   = '0;
        loop_rst    = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[15'(i)] = {16'(i * 3) ^ 16'h5A5A, 16'(i) ^ 16'hA5A5};
        end
        repeat (8) @(posedge clk);
        #1;
        test_reset_state();
        reset = 1'b0;
        test_sdram_download();
        test_prom_download();
        test_game_reset();
        test_random_reads();
        test_slot_hits();
        test_concurrent_misses();
        $display("%0d errors, %0d assertion failures", errors, u_dut.u_assert.fail_count);
        if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
rom_pkg.sv
prog_loader.sv
rom_slot.sv
rom_arbiter.sv
sdram_port.sv
rom_top.sv
rom_assert.sv
rom_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and pass only on the testbench pass line
verilator --binary --timing --assert --top-module rom_tb -f verilog.f -o rom_sim || exit 1
out=$(./obj_dir/rom_sim +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -q "TEST PASSED" && exit 0 || exit 1
